//--- csum_pkg.sv
package csum_pkg;

	// Byte count or byte position inside one frame
	typedef logic [15:0] frame_len_t;

	// Ones-complement checksum value
	typedef logic [15:0] csum_t;

	// Packed word with bytes[3] first on the wire
	// Bytes on the fill side, 16-bit halves on the adder side
	typedef union packed {
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} csum_word_t;

	// EtherType and IP protocol numbers
	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  IP_PROTO_TCP   = 8'd6;
	localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;

	// Start of the TCP or UDP header (14 byte MAC header + 20 byte IPv4 header)
	localparam frame_len_t L4_START = 16'd34;

	// Position of the checksum high byte for each protocol
	localparam frame_len_t UDP_CSUM_POS = 16'd40;
	localparam frame_len_t TCP_CSUM_POS = 16'd50;

endpackage

//--- slot_if.sv
interface slot_if (
	input logic clk,
	input logic rst_n
);
	import csum_pkg::*;

	// Byte writes from the parser
	logic       wr_en;
	frame_len_t wr_addr;
	logic [7:0] wr_data;

	// Frame metadata, valid with commit
	logic       commit;
	frame_len_t frame_len;
	csum_t      csum;
	frame_len_t csum_pos;

	// Occupancy
	logic       full;

	// Readback toward the inserter
	frame_len_t rd_addr;
	logic [7:0] rd_data;
	logic       release_en;
	frame_len_t rd_len;
	csum_t      rd_csum;
	frame_len_t rd_pos;

	modport fill (
		output wr_en, wr_addr, wr_data, commit, frame_len, csum, csum_pos,
		input  full
	);

	modport store (
		input  clk, rst_n, wr_en, wr_addr, wr_data, commit, frame_len, csum, csum_pos,
		input  rd_addr, release_en,
		output full, rd_data, rd_len, rd_csum, rd_pos
	);

	modport drain (
		output rd_addr, release_en,
		input  full, rd_data, rd_len, rd_csum, rd_pos
	);

endinterface

//--- csum_frame_parser.sv
module csum_frame_parser #(
	parameter int NUM_SLOTS  = 4,
	parameter int SLOT_BYTES = 2048
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_start,
	input  logic       in_data_valid,
	input  logic [7:0] in_data,
	output logic       in_ready,
	slot_if.fill       slots [NUM_SLOTS]
);
	import csum_pkg::*;

	localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

	// Header offsets, no VLAN tag and IHL fixed at 5
	localparam frame_len_t ETYPE_POS = 16'd12;
	localparam frame_len_t PROTO_POS = 16'd23;
	localparam frame_len_t ADDR_POS  = 16'd26;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_MAC,
		ST_IPV4,
		ST_L4,
		ST_OTHER,
		ST_LEN,
		ST_SAVE
	} state_t;

	state_t                state;
	frame_len_t            count;
	logic [SLOT_IDX_W-1:0] fill_ptr;
	logic                  commit_q;
	logic [NUM_SLOTS-1:0]  slot_full;
	logic                  receiving;
	logic                  wr_en;
	logic                  packing;
	logic                  zero_byte;
	logic [1:0]            lane;
	logic [7:0]            ethertype_hi;
	logic [7:0]            ip_proto;
	frame_len_t            csum_pos;
	csum_word_t            word_q;
	csum_word_t            pack_word;
	logic [31:0]           acc;
	logic [16:0]           fold_1;
	csum_t                 fold_2;
	csum_t                 csum_q;

	//////////////////////////////////////////////////////////////////////
	// Slot fan-out

	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		assign slot_full[i]       = slots[i].full;
		assign slots[i].wr_en     = wr_en && (fill_ptr == SLOT_IDX_W'(i));
		assign slots[i].wr_addr   = count;
		assign slots[i].wr_data   = in_data;
		assign slots[i].commit    = commit_q && (fill_ptr == SLOT_IDX_W'(i));
		assign slots[i].frame_len = count;
		assign slots[i].csum      = csum_q;
		assign slots[i].csum_pos  = csum_pos;
	end

	// Any state that still takes frame bytes
	assign receiving = (state == ST_MAC) || (state == ST_IPV4) ||
		(state == ST_L4) || (state == ST_OTHER);

	// Bytes past the end of the slot are dropped
	assign wr_en = receiving && in_data_valid && (count < SLOT_BYTES);

	// Lane inside the 32-bit word
	// Addresses start at 26 and L4 at 34, both aligned to lane 0 by this offset
	assign lane      = 2'(count - L4_START);
	assign packing   = (state == ST_L4) || ((state == ST_IPV4) && (count >= ADDR_POS));
	assign zero_byte = (csum_pos != '0) && ((count == csum_pos) || (count == csum_pos + 1'b1));

	always_comb begin
		// Drop the new byte into its lane, ~lane maps lane 0 to the top byte
		pack_word = word_q;
		pack_word.bytes[~lane] = zero_byte ? 8'h00 : in_data;

		// Two folds bring the 32-bit sum down to 16 bits
		fold_1 = {1'b0, acc[31:16]} + {1'b0, acc[15:0]};
		fold_2 = fold_1[15:0] + {15'h0, fold_1[16]};
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			count    <= '0;
			fill_ptr <= '0;
			commit_q <= 1'b0;
			in_ready <= 1'b0;
		end else begin
			commit_q <= 1'b0;

			// Idle, not committing, and the next slot has room
			in_ready <= (state == ST_IDLE) && !commit_q && !in_start && !slot_full[fill_ptr];

			// Next slot in fill order
			if (commit_q)
				fill_ptr <= (fill_ptr == SLOT_IDX_W'(NUM_SLOTS - 1)) ? '0 : fill_ptr + 1'b1;

			case (state)
				ST_IDLE: begin
					if (in_start) begin
						state <= ST_MAC;
						count <= '0;
					end
				end

				ST_LEN:
					state <= ST_SAVE;

				ST_SAVE: begin
					state    <= ST_IDLE;
					commit_q <= 1'b1;
				end

				default: begin
					// First gap in data_valid closes the frame
					if (!in_data_valid)
						state <= ST_LEN;
					else begin
						count <= count + 1'b1;

						// EtherType decides IPv4 or pass-through
						if ((state == ST_MAC) && (count == ETYPE_POS + 1'b1))
							state <= ({ethertype_hi, in_data} == ETHERTYPE_IPV4) ? ST_IPV4 : ST_OTHER;

						// Last IP header byte, pick the L4 path
						if ((state == ST_IPV4) && (count == L4_START - 1'b1))
							state <= ((ip_proto == IP_PROTO_TCP) || (ip_proto == IP_PROTO_UDP)) ?
								ST_L4 : ST_OTHER;
					end
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checksum datapath

	always_ff @(posedge clk) begin
		if ((state == ST_IDLE) && in_start) begin
			acc      <= '0;
			word_q   <= '0;
			csum_pos <= '0;
		end else if (receiving && in_data_valid) begin
			if ((state == ST_MAC) && (count == ETYPE_POS))
				ethertype_hi <= in_data;

			// Protocol enters the pseudo-header as a zero-extended word
			if ((state == ST_IPV4) && (count == PROTO_POS)) begin
				ip_proto <= in_data;
				acc      <= acc + {24'h0, in_data};
			end

			// Remember where the inserter must patch
			if ((state == ST_IPV4) && (count == L4_START - 1'b1)) begin
				if (ip_proto == IP_PROTO_TCP)
					csum_pos <= TCP_CSUM_POS;
				else if (ip_proto == IP_PROTO_UDP)
					csum_pos <= UDP_CSUM_POS;
			end

			// Addresses and segment, one word every four bytes
			if (packing) begin
				if (lane == 2'd3) begin
					acc    <= acc + pack_word.halves[1] + pack_word.halves[0];
					word_q <= '0;
				end else
					word_q <= pack_word;
			end
		end else if (receiving) begin
			// Partial word, unused lanes already zero
			acc <= acc + word_q.halves[1] + word_q.halves[0];
		end else if (state == ST_LEN) begin
			// Segment length from the pseudo-header
			acc <= acc + frame_len_t'(count - L4_START);
		end else if (state == ST_SAVE) begin
			csum_q <= ~fold_2;
		end
	end

endmodule

//--- frame_slot.sv
module frame_slot #(
	parameter int SLOT_BYTES = 2048
) (
	slot_if.store port
);

	localparam int ADDR_W = $clog2(SLOT_BYTES);

	// Frame bytes
	logic [7:0] mem [SLOT_BYTES];

	//////////////////////////////////////////////////////////////////////
	// Byte RAM

	// Write from the parser, registered read toward the inserter
	always_ff @(posedge port.clk) begin
		if (port.wr_en)
			mem[port.wr_addr[ADDR_W-1:0]] <= port.wr_data;
		port.rd_data <= mem[port.rd_addr[ADDR_W-1:0]];
	end

	//////////////////////////////////////////////////////////////////////
	// Metadata

	// Length, checksum and patch offset of the stored frame
	always_ff @(posedge port.clk) begin
		if (port.commit) begin
			port.rd_len  <= port.frame_len;
			port.rd_csum <= port.csum;
			port.rd_pos  <= port.csum_pos;
		end
	end

	// Full from commit until the inserter lets go
	always_ff @(posedge port.clk or negedge port.rst_n) begin
		if (!port.rst_n)
			port.full <= 1'b0;
		else if (port.commit)
			port.full <= 1'b1;
		else if (port.release_en)
			port.full <= 1'b0;
	end

endmodule

//--- csum_inserter.sv
module csum_inserter #(
	parameter int NUM_SLOTS = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_ready,
	output logic       tx_start,
	output logic       tx_data_valid,
	output logic [7:0] tx_data,
	slot_if.drain      slots [NUM_SLOTS]
);
	import csum_pkg::*;

	localparam int SLOT_IDX_W = $clog2(NUM_SLOTS);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_PRIME,
		RD_FORWARD,
		RD_LAST
	} rd_state_t;

	rd_state_t             rd_state;
	logic [SLOT_IDX_W-1:0] drain_ptr;
	frame_len_t            rd_addr;
	logic                  release_q;
	logic [NUM_SLOTS-1:0]  slot_full;
	logic [7:0]            slot_data [NUM_SLOTS];
	frame_len_t            slot_len  [NUM_SLOTS];
	csum_t                 slot_csum [NUM_SLOTS];
	frame_len_t            slot_pos  [NUM_SLOTS];
	frame_len_t            byte_pos;
	logic [7:0]            tx_byte;

	// Gather slot outputs, broadcast the read address
	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		assign slot_full[i]         = slots[i].full;
		assign slot_data[i]         = slots[i].rd_data;
		assign slot_len[i]          = slots[i].rd_len;
		assign slot_csum[i]         = slots[i].rd_csum;
		assign slot_pos[i]          = slots[i].rd_pos;
		assign slots[i].rd_addr     = rd_addr;
		assign slots[i].release_en  = release_q && (drain_ptr == SLOT_IDX_W'(i));
	end

	// rd_data trails rd_addr by one byte
	always_comb begin
		byte_pos = rd_addr - 1'b1;
		tx_byte  = slot_data[drain_ptr];
		// Zero offset means nothing to patch
		if (slot_pos[drain_ptr] != '0) begin
			if (byte_pos == slot_pos[drain_ptr])
				tx_byte = slot_csum[drain_ptr][15:8];
			else if (byte_pos == slot_pos[drain_ptr] + 1'b1)
				tx_byte = slot_csum[drain_ptr][7:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Readback FSM

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_state      <= RD_IDLE;
			drain_ptr     <= '0;
			rd_addr       <= '0;
			release_q     <= 1'b0;
			tx_start      <= 1'b0;
			tx_data_valid <= 1'b0;
		end else begin
			tx_start      <= 1'b0;
			tx_data_valid <= 1'b0;
			release_q     <= 1'b0;

			if (release_q)
				drain_ptr <= (drain_ptr == SLOT_IDX_W'(NUM_SLOTS - 1)) ? '0 : drain_ptr + 1'b1;

			case (rd_state)
				// MAC ready is only looked at here, frames never stall once started
				RD_IDLE: begin
					if (tx_ready && slot_full[drain_ptr] && !release_q) begin
						tx_start <= 1'b1;
						rd_addr  <= '0;
						rd_state <= RD_PRIME;
					end
				end

				// First read in flight
				RD_PRIME: begin
					rd_addr  <= rd_addr + 1'b1;
					rd_state <= (slot_len[drain_ptr] > 16'd1) ? RD_FORWARD : RD_LAST;
				end

				RD_FORWARD: begin
					tx_data_valid <= 1'b1;
					rd_addr       <= rd_addr + 1'b1;
					if ((rd_addr + 1'b1) >= slot_len[drain_ptr])
						rd_state <= RD_LAST;
				end

				// Final byte goes out together with the release
				RD_LAST: begin
					tx_data_valid <= 1'b1;
					release_q     <= 1'b1;
					rd_state      <= RD_IDLE;
				end
			endcase
		end
	end

	// Output byte with checksum patched in
	always_ff @(posedge clk) begin
		if ((rd_state == RD_FORWARD) || (rd_state == RD_LAST))
			tx_data <= tx_byte;
	end

endmodule

//--- csum_offload.sv
module csum_offload #(
	parameter int NUM_SLOTS  = 4,
	parameter int SLOT_BYTES = 2048
) (
	input  logic       clk,
	input  logic       rst_n,

	// From the transmit buffer
	input  logic       in_start,
	input  logic       in_data_valid,
	input  logic [7:0] in_data,
	output logic       in_ready,

	// Toward the MAC
	input  logic       tx_ready,
	output logic       tx_start,
	output logic       tx_data_valid,
	output logic [7:0] tx_data
);

	// One bus per frame slot
	slot_if slot_bus [NUM_SLOTS] (
		.clk   (clk),
		.rst_n (rst_n)
	);

	//////////////////////////////////////////////////////////////////////
	// Header parse and checksum

	csum_frame_parser #(
		.NUM_SLOTS  (NUM_SLOTS),
		.SLOT_BYTES (SLOT_BYTES)
	) u_parser (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_start      (in_start),
		.in_data_valid (in_data_valid),
		.in_data       (in_data),
		.in_ready      (in_ready),
		.slots         (slot_bus)
	);

	// Frame slots, filled and drained round robin
	for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
		frame_slot #(
			.SLOT_BYTES (SLOT_BYTES)
		) u_slot (
			.port (slot_bus[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Readback and checksum insertion

	csum_inserter #(
		.NUM_SLOTS (NUM_SLOTS)
	) u_inserter (
		.clk           (clk),
		.rst_n         (rst_n),
		.tx_ready      (tx_ready),
		.tx_start      (tx_start),
		.tx_data_valid (tx_data_valid),
		.tx_data       (tx_data),
		.slots         (slot_bus)
	);

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	// Free-running clock, first rising edge half a period in
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset held over the first few rising edges, released just after one
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(PERIOD / 10);
		rst_n = 1'b1;
	end

endmodule

//--- csum_offload_asserts.sv
module csum_offload_asserts (
	input logic clk,
	input logic rst_n,
	input logic in_start,
	input logic in_ready,
	input logic tx_start,
	input logic tx_data_valid
);

	// Failures so far, watched from the testbench top
	int fail_count = 0;

	// Frame start never overlaps frame data
	a_start_apart: assert property (@(posedge clk) disable iff (!rst_n)
		!(tx_start && tx_data_valid))
	else begin
		$error("tx_start and tx_data_valid high in the same cycle");
		fail_count++;
	end

	// Sender only starts a frame when the parser can take it
	a_start_ready: assert property (@(posedge clk) disable iff (!rst_n)
		in_start |-> in_ready)
	else begin
		$error("in_start while in_ready is low");
		fail_count++;
	end

	// Two cycles of read latency between start and first byte
	a_data_delay: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |-> ##2 $rose(tx_data_valid))
	else begin
		$error("tx_data_valid did not rise two cycles after tx_start");
		fail_count++;
	end

	// Quiet outputs while reset is held, looked at mid-cycle
	a_reset_quiet: assert property (@(negedge clk)
		!rst_n |-> (!tx_start && !tx_data_valid && !in_ready))
	else begin
		$error("output active during reset");
		fail_count++;
	end

endmodule

bind csum_offload csum_offload_asserts u_asserts (
	.clk           (clk),
	.rst_n         (rst_n),
	.in_start      (in_start),
	.in_ready      (in_ready),
	.tx_start      (tx_start),
	.tx_data_valid (tx_data_valid)
);

//--- tb_csum_offload.sv
module tb_csum_offload;

	localparam int NUM_SLOTS   = 4;
	localparam int SLOT_BYTES  = 2048;
	localparam int MAX_ENTRIES = 1024;
	localparam int DRIVE_DELAY = 10;

	logic       clk;
	logic       rst_n;
	logic       in_start;
	logic       in_data_valid;
	logic [7:0] in_data;
	logic       in_ready;
	logic       tx_ready;
	logic       tx_start;
	logic       tx_data_valid;
	logic [7:0] tx_data;

	// Tag in bits 11:8, byte in bits 7:0
	logic [11:0] testdata [MAX_ENTRIES];

	int     num_entries    = 0;
	int     expected_total = 0;
	int     cycle_limit    = 0;
	int     cycles         = 0;
	int     frames_sent    = 0;
	int     frames_started = 0;
	int     bytes_seen     = 0;
	int     exp_idx        = 0;
	int     span;
	bit     start_seen     = 1'b0;
	bit     new_frame;
	integer seed           = 32'he9f6;

	tb_clock_gen #(
		.PERIOD       (100),
		.RESET_CYCLES (3)
	) u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	csum_offload #(
		.NUM_SLOTS  (NUM_SLOTS),
		.SLOT_BYTES (SLOT_BYTES)
	) u_csum_offload (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_start      (in_start),
		.in_data_valid (in_data_valid),
		.in_data       (in_data),
		.in_ready      (in_ready),
		.tx_ready      (tx_ready),
		.tx_start      (tx_start),
		.tx_data_valid (tx_data_valid),
		.tx_data       (tx_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Failure reporting

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("Error %s expected 0x%02h got 0x%02h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1);
		end
	endtask

	// Count expected bytes and find the end tag
	task automatic scan_testdata();
		int i;
		i = 0;
		while ((i < MAX_ENTRIES) && !$isunknown(testdata[i]) && (testdata[i][11:8] != 4'h3)) begin
			if (testdata[i][11:8] == 4'h2)
				expected_total++;
			i++;
		end
		if ((i == MAX_ENTRIES) || $isunknown(testdata[i]))
			abort_run("Test data file has no end marker");
		else begin
			num_entries = i + 1;
			cycle_limit = 4 * num_entries + 1000;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Input driver

	// Wait for room, then a one-cycle start pulse
	task automatic start_frame();
		while (!in_ready) begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		in_start = 1'b1;
		frames_started++;
		@(posedge clk);
		#DRIVE_DELAY;
		in_start = 1'b0;
	endtask

	// Bytes back to back, valid drops on the end tag
	task automatic drive_frames();
		int ptr;
		bit in_frame;
		ptr      = 0;
		in_frame = 1'b0;
		while (testdata[ptr][11:8] != 4'h3) begin
			case (testdata[ptr][11:8])
				4'h0: begin
					if (!in_frame) begin
						start_frame();
						in_frame = 1'b1;
					end
					in_data_valid = 1'b1;
					in_data       = testdata[ptr][7:0];
					@(posedge clk);
					#DRIVE_DELAY;
				end
				4'h1: begin
					in_data_valid = 1'b0;
					in_data       = 8'h00;
					in_frame      = 1'b0;
					frames_sent++;
				end
				default: ;
			endcase
			ptr++;
		end
	endtask

	initial begin
		in_start      = 1'b0;
		in_data_valid = 1'b0;
		in_data       = 8'h00;
		tx_ready      = 1'b0;
		$readmemh("csum_offload_testdata.hex", testdata);
		scan_testdata();
		wait (rst_n === 1'b1);
		@(posedge clk);
		#DRIVE_DELAY;
		drive_frames();
		wait (bytes_seen == expected_total);
		repeat (4) @(posedge clk);
		if (u_csum_offload.u_asserts.fail_count != 0) begin
			$display("STATUS: FAIL");
			$fatal(1);
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// MAC side

	// Hold off until every slot is full, then random low spans
	initial begin
		wait (rst_n === 1'b1);
		wait (frames_sent == NUM_SLOTS);
		repeat (20) @(posedge clk);
		#DRIVE_DELAY;
		// All slots taken, the sender has to wait
		compare_value("in_ready", 8'h00, {7'h0, in_ready});
		// Next frame still held back
		compare_value("frames_started", 8'(NUM_SLOTS), 8'(frames_started));
		forever begin
			tx_ready = 1'b1;
			@(posedge clk);
			#DRIVE_DELAY;
			span = $random(seed) & 32'h7;
			if (span != 0) begin
				tx_ready = 1'b0;
				repeat (span) @(posedge clk);
				#DRIVE_DELAY;
			end
		end
	end

	// Outputs settle by the falling edge
	always @(negedge clk) begin
		if (rst_n && tx_start)
			start_seen = 1'b1;
		if (rst_n && tx_data_valid) begin
			if (bytes_seen >= expected_total)
				abort_run("Output byte seen after the last expected byte");
			else begin
				// Skipped input entries mean this byte opens a new frame
				new_frame = 1'b0;
				while (testdata[exp_idx][11:8] != 4'h2) begin
					new_frame = 1'b1;
					exp_idx++;
				end
				// One tx_start ahead of each frame and none inside it
				compare_value("tx_start", {7'h0, new_frame}, {7'h0, start_seen});
				start_seen = 1'b0;
				compare_value("tx_data", testdata[exp_idx][7:0], tx_data);
				exp_idx++;
				bytes_seen++;
			end
		end
	end

	// Stop at the first assertion failure
	initial begin
		wait (u_csum_offload.u_asserts.fail_count != 0);
		abort_run("A protocol assertion failed");
	end

	// Run length bound
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit)
			abort_run($sformatf("Timeout after %0d cycles, %0d of %0d output bytes seen",
				cycles, bytes_seen, expected_total));
	end

endmodule

//--- csum_offload.f
csum_pkg.sv
slot_if.sv
csum_frame_parser.sv
frame_slot.sv
csum_inserter.sv
csum_offload.sv
tb_clock_gen.sv
csum_offload_asserts.sv
tb_csum_offload.sv

//--- csum_offload_testdata.hex
// One entry per word: tag in the top digit, byte in the low two digits
// 0xx input byte, 100 end of input frame, 2xx expected output byte, 300 end of data
// UDP/IPv4, 3 byte payload, stale 1234 replaced by 0c73 at bytes 40 and 41
002 000 000 000 000 002 002 000 000 000 000 001 008 000
045 000 000 01f 000 001 000 000 040 011 000 000 00a 000 000 001 00a 000 000 002
004 0d2 016 02e 000 00b 012 034 061 062 063 100
202 200 200 200 200 202 202 200 200 200 200 201 208 200
245 200 200 21f 200 201 200 200 240 211 200 200 20a 200 200 201 20a 200 200 202
204 2d2 216 22e 200 20b 20c 273 261 262 263
// TCP/IPv4, 1 byte payload, ffff replaced by 45a6 at bytes 50 and 51
002 000 000 000 000 002 002 000 000 000 000 001 008 000
045 000 000 029 000 002 000 000 040 006 000 000 00a 000 000 001 00a 000 000 002
004 0d2 000 050 000 000 000 001 000 000 000 000 050 018 010 000 0ff 0ff 000 000 041 100
202 200 200 200 200 202 202 200 200 200 200 201 208 200
245 200 200 229 200 202 200 200 240 206 200 200 20a 200 200 201 20a 200 200 202
204 2d2 200 250 200 200 200 201 200 200 200 200 250 218 210 200 245 2a6 200 200 241
// ARP request, passes unchanged
0ff 0ff 0ff 0ff 0ff 0ff 002 000 000 000 000 001 008 006
000 001 008 000 006 004 000 001 002 000 000 000 000 001 00a 000 000 001 000 000
000 000 000 000 00a 000 000 002 100
2ff 2ff 2ff 2ff 2ff 2ff 202 200 200 200 200 201 208 206
200 201 208 200 206 204 200 201 202 200 200 200 200 201 20a 200 200 201 200 200
200 200 200 200 20a 200 200 202
// ICMP echo over IPv4, passes unchanged
002 000 000 000 000 002 002 000 000 000 000 001 008 000
045 000 000 01c 000 003 000 000 040 001 000 000 00a 000 000 001 00a 000 000 002
008 000 0f7 0ff 000 000 000 000 100
202 200 200 200 200 202 202 200 200 200 200 201 208 200
245 200 200 21c 200 203 200 200 240 201 200 200 20a 200 200 201 20a 200 200 202
208 200 2f7 2ff 200 200 200 200
// UDP/IPv4, no payload, sum carries out of 16 bits, fcd5 at bytes 40 and 41
002 000 000 000 000 004 002 000 000 000 000 003 008 000
045 000 000 01c 000 004 000 000 040 011 000 000 00a 000 000 003 00a 000 000 004
0f0 000 0ff 000 000 008 000 000 100
202 200 200 200 200 204 202 200 200 200 200 203 208 200
245 200 200 21c 200 204 200 200 240 211 200 200 20a 200 200 203 20a 200 200 204
2f0 200 2ff 200 200 208 2fc 2d5
300
